// ==== filelist.f ====
+incdir+rtl
rtl/wrot_pkg.sv
rtl/beat_packer.sv
rtl/weight_bank.sv
rtl/loop_counter.sv
rtl/rotator_ctrl.sv
rtl/weight_rotator.sv
verif/weight_rotator_chk.sv
verif/weight_rotator_tb.sv

// ==== rtl/beat_packer.sv ====
`timescale 1ns/1ps
`include "wrot_config.svh"

module beat_packer (
  input  logic                  aclk,
  input  logic                  aresetn,
  // Narrow weight beats
  input  logic                  i_valid,
  output logic                  o_ready,
  input  wrot_pkg::wrot_beat_u  i_data,
  input  logic                  i_last,
  // Wide rows
  output logic                  o_valid,
  input  logic                  i_ready,
  output logic [`WROT_M_W-1:0]  o_row,
  output logic                  o_last
);

  logic                 have_low;   // Low half already captured
  logic [`WROT_S_W-1:0] low_q;
  logic                 row_vld;
  logic [`WROT_M_W-1:0] row_q;
  logic                 row_last_q;
  logic                 in_fire;
  logic                 out_fire;

  assign in_fire  = i_valid && o_ready;
  assign out_fire = row_vld && i_ready;

  // Room for a beat unless a full row is stuck
  assign o_ready = !row_vld || i_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      have_low <= 1'b0;
      row_vld  <= 1'b0;
    end else begin
      if (in_fire)
        have_low <= !have_low;
      if (in_fire && have_low)
        row_vld <= 1'b1;
      else if (out_fire)
        row_vld <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_fire && !have_low)
      low_q <= i_data.w;
    if (in_fire && have_low) begin
      row_q      <= {i_data.w, low_q};  // First beat lands in the low half
      row_last_q <= i_last;
    end
  end

  assign o_valid = row_vld;
  assign o_row   = row_q;
  assign o_last  = row_last_q;

endmodule

// ==== rtl/loop_counter.sv ====
`timescale 1ns/1ps
`include "wrot_config.svh"

module loop_counter #(
  parameter int WIDTH = 4
) (
  input  logic             aclk,
  input  logic             i_clear,
  input  logic             i_en,
  input  logic [WIDTH-1:0] i_max,
  output logic [WIDTH-1:0] o_count,
  output logic             o_first,
  output logic             o_last,
  output logic             o_wrap    // Steps the next counter out
);

  always_ff @(posedge aclk) begin
    if (i_clear)
      o_count <= '0;
    else if (i_en)
      o_count <= o_last ? '0 : o_count + 1'b1;
  end

  assign o_first = (o_count == '0);
  assign o_last  = (o_count == i_max);
  assign o_wrap  = o_last && i_en;

endmodule

// ==== rtl/rotator_ctrl.sv ====
`timescale 1ns/1ps
`include "wrot_config.svh"

module rotator_ctrl (
  input  logic                 aclk,
  input  logic                 aresetn,
  // Input stream, header side
  input  logic                 i_s_valid,
  input  logic                 i_s_last,
  input  wrot_pkg::wrot_hdr_t  i_hdr,
  output logic                 o_hdr_ready,
  output logic                 o_hdr_phase,   // Input beats go to the header path
  // Packed rows
  input  logic                 i_row_valid,
  input  logic                 i_row_last,
  output logic                 o_row_ready,
  // Bank controls
  output logic [1:0]           o_wen,
  output logic [1:0]           o_clear,
  output logic [1:0]           o_ren,
  // Read side
  input  logic                 i_m_ready,
  input  logic                 i_out_fire,
  input  logic                 i_blk_wrap,
  output logic                 o_start_read,
  output wrot_pkg::wrot_hdr_t  o_rd_hdr,
  output logic                 o_is_config,
  output logic                 o_read_active,
  output logic                 o_rd_sel
);

  import wrot_pkg::*;

  wrot_wstate_e wstate;
  wrot_rstate_e rstate;
  logic         wr_sel;
  logic         tail;           // Final weight beat already taken
  logic [1:0]   done_write;
  logic [1:0]   done_read;
  wrot_hdr_t    hdr_q [2];
  logic         hdr_fire;
  logic         row_fire;
  logic         start_write;

  assign hdr_fire     = i_s_valid && o_hdr_ready;
  assign row_fire     = i_row_valid && o_row_ready;
  assign start_write  = (wstate == W_IDLE) && done_read[wr_sel];
  assign o_start_read = (rstate == R_IDLE) && done_write[o_rd_sel];

  // Write side
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wstate <= W_IDLE;
      wr_sel <= 1'b0;
    end else begin
      case (wstate)
        W_IDLE:    if (start_write) wstate <= W_GET_HDR;
        W_GET_HDR: if (hdr_fire) wstate <= W_WRITE;
        W_WRITE:   if (row_fire && i_row_last) wstate <= W_FLUSH;
        W_FLUSH:   wstate <= W_SWITCH;  // Last row settles in the bank
        W_SWITCH: begin
          wstate <= W_IDLE;
          wr_sel <= !wr_sel;
        end
        default:   wstate <= W_IDLE;
      endcase
    end
  end

  // The packer is always ready in the write state, so valid with last
  // here marks the final input beat
  always_ff @(posedge aclk) begin
    if (!aresetn || wstate != W_WRITE)
      tail <= 1'b0;
    else if (i_s_valid && i_s_last)
      tail <= 1'b1;
  end

  // Read side
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rstate   <= R_IDLE;
      o_rd_sel <= 1'b0;
    end else begin
      case (rstate)
        R_IDLE:     if (o_start_read) rstate <= R_PASS_CFG;
        R_PASS_CFG: if (i_out_fire) rstate <= R_READ;
        R_READ:     if (i_blk_wrap) rstate <= R_SWITCH;
        R_SWITCH: begin
          rstate   <= R_IDLE;
          o_rd_sel <= !o_rd_sel;
        end
        default:    rstate <= R_IDLE;
      endcase
    end
  end

  // Bank handover between the two machines
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      done_write <= 2'b00;
      done_read  <= 2'b11;  // Both banks free to fill
    end else begin
      if (start_write)
        done_write[wr_sel] <= 1'b0;
      if (wstate == W_SWITCH)
        done_write[wr_sel] <= 1'b1;
      if (o_start_read)
        done_read[o_rd_sel] <= 1'b0;
      if (rstate == R_SWITCH)
        done_read[o_rd_sel] <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (hdr_fire)
      hdr_q[wr_sel] <= i_hdr;
  end

  assign o_hdr_ready   = (wstate == W_GET_HDR);
  assign o_hdr_phase   = (wstate != W_WRITE) || tail;
  assign o_row_ready   = (wstate == W_WRITE);
  assign o_rd_hdr      = hdr_q[o_rd_sel];
  assign o_is_config   = (rstate == R_PASS_CFG);
  assign o_read_active = (rstate == R_READ);

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      o_wen[i]   = (wr_sel == i) && (wstate == W_WRITE) && i_row_valid;
      o_clear[i] = (wr_sel == i) && (wstate == W_GET_HDR);
      o_ren[i]   = (o_rd_sel == i) && (rstate == R_READ) && i_m_ready;  // Skid never overflows
    end
  end

endmodule

// ==== rtl/weight_bank.sv ====
`timescale 1ns/1ps
`include "wrot_config.svh"

module weight_bank (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    i_clear,     // Restart both pointers
  input  logic                    i_wen,
  input  logic [`WROT_M_W-1:0]    i_wdata,
  input  logic [`WROT_ADDR_W-1:0] i_rows_1,    // Last read address before wrap
  input  logic                    i_ren,
  output logic [`WROT_M_W-1:0]    o_rdata
);

  logic [`WROT_M_W-1:0]    mem [`WROT_DEPTH];
  logic [`WROT_ADDR_W-1:0] wptr;
  logic [`WROT_ADDR_W-1:0] rptr;

  // Read data pipe, stage 0 is the array output register
  logic [`WROT_LAT-1:0][`WROT_M_W-1:0] pipe;

  always_ff @(posedge aclk) begin
    if (!aresetn || i_clear) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (i_wen)
        wptr <= wptr + 1'b1;
      if (i_ren) begin
        if (rptr == i_rows_1)
          rptr <= '0;
        else
          rptr <= rptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_wen)
      mem[wptr] <= i_wdata;
  end

  // Fixed latency, later stages shift every cycle
  always_ff @(posedge aclk) begin
    if (i_ren)
      pipe[0] <= mem[rptr];
    for (int k = 1; k < `WROT_LAT; k++) begin
      pipe[k] <= pipe[k-1];
    end
  end

  assign o_rdata = pipe[`WROT_LAT-1];

endmodule

// ==== rtl/weight_rotator.sv ====
`timescale 1ns/1ps
`include "wrot_config.svh"

module weight_rotator (
  input  logic                   aclk,
  input  logic                   aresetn,
  // Input stream
  input  logic                   i_s_valid,
  output logic                   o_s_ready,
  input  wrot_pkg::wrot_beat_u   i_s_data,
  input  logic                   i_s_last,
  // Output stream
  output logic                   o_m_valid,
  input  logic                   i_m_ready,
  output logic [`WROT_M_W-1:0]   o_m_data,
  output logic                   o_m_last,
  output logic                   o_m_is_config,
  output logic [`WROT_KW2_W-1:0] o_m_kw2,
  output logic                   o_m_is_w_first,
  output logic                   o_m_is_cin_last,
  output logic                   o_m_is_w_last
);

  import wrot_pkg::*;

  localparam int SKID_N = `WROT_LAT + 1;   // Rows in flight plus the head
  localparam int SKID_PW = $clog2(SKID_N);
  localparam int SKID_CW = $clog2(SKID_N + 1);

  logic                 hdr_ready, hdr_phase;
  logic                 pk_valid, pk_ready;
  logic                 row_valid, row_ready, row_last;
  logic [`WROT_M_W-1:0] row_data;
  logic [1:0]           wen, clear, ren;
  logic [`WROT_M_W-1:0] bank_rdata [2];
  logic                 start_read, is_config, read_active, rd_sel;
  wrot_hdr_t            rd_hdr;
  logic                 out_fire, row_fire;
  logic                 k_first, k_last, k_wrap;
  logic                 c_first, c_last, c_wrap;
  logic                 col_first, col_last, col_wrap;
  logic                 b_last, b_wrap;

  logic [`WROT_LAT-1:0] rd_vld;                 // Tracks bank read pipe
  logic [`WROT_M_W-1:0] skid_mem [SKID_N];
  logic [SKID_PW-1:0]   skid_wp, skid_rp;
  logic [SKID_CW-1:0]   skid_cnt;
  logic                 skid_push;

  // Header beat to the controller, weights to the packer
  assign pk_valid  = i_s_valid && !hdr_phase;
  assign o_s_ready = hdr_phase ? hdr_ready : pk_ready;

  beat_packer u_packer (
    .aclk    (aclk),
    .aresetn (aresetn),
    .i_valid (pk_valid),
    .o_ready (pk_ready),
    .i_data  (i_s_data),
    .i_last  (i_s_last),
    .o_valid (row_valid),
    .i_ready (row_ready),
    .o_row   (row_data),
    .o_last  (row_last)
  );

  for (genvar i = 0; i < 2; i++) begin : g_bank
    weight_bank u_bank (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .i_clear  (clear[i]),
      .i_wen    (wen[i]),
      .i_wdata  (row_data),
      .i_rows_1 (rd_hdr.rows_1),
      .i_ren    (ren[i]),
      .o_rdata  (bank_rdata[i])
    );
  end

  rotator_ctrl u_ctrl (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_s_valid     (i_s_valid),
    .i_s_last      (i_s_last),
    .i_hdr         (i_s_data.hdr),
    .o_hdr_ready   (hdr_ready),
    .o_hdr_phase   (hdr_phase),
    .i_row_valid   (row_valid),
    .i_row_last    (row_last),
    .o_row_ready   (row_ready),
    .o_wen         (wen),
    .o_clear       (clear),
    .o_ren         (ren),
    .i_m_ready     (i_m_ready),
    .i_out_fire    (out_fire),
    .i_blk_wrap    (b_wrap),
    .o_start_read  (start_read),
    .o_rd_hdr      (rd_hdr),
    .o_is_config   (is_config),
    .o_read_active (read_active),
    .o_rd_sel      (rd_sel)
  );

  // Kernel runs fastest, then channel, column, block
  loop_counter #(.WIDTH(`WROT_KW2_W + 1)) u_cnt_kw (
    .aclk (aclk), .i_clear (start_read), .i_en (row_fire), .i_max ({rd_hdr.kw2, 1'b0}),
    .o_count (), .o_first (k_first), .o_last (k_last), .o_wrap (k_wrap)
  );

  loop_counter #(.WIDTH(`WROT_CIN_W)) u_cnt_cin (
    .aclk (aclk), .i_clear (start_read), .i_en (k_wrap), .i_max (rd_hdr.cin_1),
    .o_count (), .o_first (c_first), .o_last (c_last), .o_wrap (c_wrap)
  );

  loop_counter #(.WIDTH(`WROT_COLS_W)) u_cnt_col (
    .aclk (aclk), .i_clear (start_read), .i_en (c_wrap), .i_max (rd_hdr.cols_1),
    .o_count (), .o_first (col_first), .o_last (col_last), .o_wrap (col_wrap)
  );

  loop_counter #(.WIDTH(`WROT_BLK_W)) u_cnt_blk (
    .aclk (aclk), .i_clear (start_read), .i_en (col_wrap), .i_max (rd_hdr.blocks_1),
    .o_count (), .o_first (), .o_last (b_last), .o_wrap (b_wrap)
  );

  assign skid_push = rd_vld[`WROT_LAT-1];
  assign out_fire  = o_m_valid && i_m_ready;
  assign row_fire  = out_fire && read_active;

  // Skid FIFO, emptied whenever the read state is left so surplus
  // reads at the end of a packet are dropped
  always_ff @(posedge aclk) begin
    if (!aresetn || !read_active) begin
      rd_vld   <= '0;
      skid_wp  <= '0;
      skid_rp  <= '0;
      skid_cnt <= '0;
    end else begin
      rd_vld[0] <= |ren;
      for (int k = 1; k < `WROT_LAT; k++) begin
        rd_vld[k] <= rd_vld[k-1];
      end
      if (skid_push)
        skid_wp <= (skid_wp == SKID_PW'(SKID_N - 1)) ? '0 : skid_wp + 1'b1;
      if (row_fire)
        skid_rp <= (skid_rp == SKID_PW'(SKID_N - 1)) ? '0 : skid_rp + 1'b1;
      case ({skid_push, row_fire})
        2'b10:   skid_cnt <= skid_cnt + 1'b1;
        2'b01:   skid_cnt <= skid_cnt - 1'b1;
        default: skid_cnt <= skid_cnt;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (skid_push)
      skid_mem[skid_wp] <= rd_sel ? bank_rdata[1] : bank_rdata[0];
  end

  // Config beat comes straight from the stored header
  assign o_m_valid = is_config || (read_active && skid_cnt != '0);
  assign o_m_data  = is_config ? {{(`WROT_M_W - `WROT_S_W){1'b0}}, rd_hdr} : skid_mem[skid_rp];

  assign o_m_is_config   = is_config;
  assign o_m_kw2         = rd_hdr.kw2;
  assign o_m_is_w_first  = read_active && col_first && c_first && k_first;
  assign o_m_is_cin_last = read_active && k_last && c_last;
  assign o_m_is_w_last   = read_active && col_last;
  assign o_m_last        = read_active && b_last && col_last && c_last && k_last;

endmodule

// ==== rtl/wrot_config.svh ====
`ifndef WROT_CONFIG_SVH
`define WROT_CONFIG_SVH

// Datapath sizes
`define WROT_WORD_W  8              // One weight word
`define WROT_COLS    8              // Processing columns, words per output row
`define WROT_S_W     32             // Input beat, half an output row
`define WROT_M_W     64             // Output row

// Weight bank
`define WROT_DEPTH   64             // Rows per bank
`define WROT_LAT     2              // Read latency in cycles

// Header field widths
`define WROT_KW2_W   2
`define WROT_CIN_W   4
`define WROT_COLS_W  4
`define WROT_BLK_W   3
`define WROT_ADDR_W  6

`endif

// ==== rtl/wrot_pkg.sv ====
`include "wrot_config.svh"

package wrot_pkg;

  localparam int HDR_W = `WROT_KW2_W + `WROT_CIN_W + `WROT_COLS_W + `WROT_BLK_W + `WROT_ADDR_W;
  localparam int BEAT_WORDS = `WROT_S_W / `WROT_WORD_W;

  // Configuration header, low bits hold kw2
  typedef struct packed {
    logic [`WROT_S_W-HDR_W-1:0] pad;       // Zero fill up to beat width
    logic [`WROT_ADDR_W-1:0]    rows_1;    // Stored rows minus one
    logic [`WROT_BLK_W-1:0]     blocks_1;  // Row blocks minus one
    logic [`WROT_COLS_W-1:0]    cols_1;    // Image columns minus one
    logic [`WROT_CIN_W-1:0]     cin_1;     // Channels minus one
    logic [`WROT_KW2_W-1:0]     kw2;       // Kernel width is 2*kw2+1
  } wrot_hdr_t;

  // One input beat, either the header or four weight words
  typedef union packed {
    wrot_hdr_t                                   hdr;
    logic [BEAT_WORDS-1:0][`WROT_WORD_W-1:0]     w;
  } wrot_beat_u;

  typedef enum logic [2:0] {
    W_IDLE,
    W_GET_HDR,
    W_WRITE,
    W_FLUSH,
    W_SWITCH
  } wrot_wstate_e;

  typedef enum logic [1:0] {
    R_IDLE,
    R_PASS_CFG,
    R_READ,
    R_SWITCH
  } wrot_rstate_e;

endpackage

// ==== verif/weight_rotator_chk.sv ====
`timescale 1ns/1ps
`include "wrot_config.svh"

module weight_rotator_chk (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   i_valid,
  input  logic                   i_ready,
  input  logic [`WROT_M_W-1:0]   i_data,
  input  logic                   i_last,
  input  logic                   i_is_config,
  input  logic [`WROT_KW2_W-1:0] i_kw2,
  input  logic                   i_w_first,
  input  logic                   i_cin_last,
  input  logic                   i_w_last
);

  int unsigned fail_count = 0;  // Watched by the testbench

  // Stalled beat keeps valid high
  a_valid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    i_valid && !i_ready |=> i_valid)
    else begin
      $error("Output valid dropped before the beat was taken");
      fail_count++;
    end

  a_payload_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    i_valid && !i_ready |=> $stable({i_data, i_last, i_is_config, i_kw2,
                                     i_w_first, i_cin_last, i_w_last}))
    else begin
      $error("Output payload changed while the beat was stalled");
      fail_count++;
    end

  // Quiet output through reset and the first cycle out of it
  a_reset_quiet: assert property (@(posedge aclk) !aresetn |=> !i_valid)
    else begin
      $error("Output valid high during reset");
      fail_count++;
    end

  a_after_reset: assert property (@(posedge aclk) $rose(aresetn) |=> !i_valid)
    else begin
      $error("Output valid high in the cycle after reset");
      fail_count++;
    end

endmodule

// ==== verif/weight_rotator_tb.sv ====
`timescale 1ns/1ps
`include "wrot_config.svh"

module weight_rotator_tb;

  import wrot_pkg::*;

  localparam int N_PKT = 12;

  typedef struct packed {
    logic [`WROT_M_W-1:0]   data;
    logic                   last;
    logic                   is_config;
    logic [`WROT_KW2_W-1:0] kw2;
    logic                   w_first;
    logic                   cin_last;
    logic                   w_last;
  } out_beat_t;

  logic                   aclk;
  logic                   aresetn;
  logic                   i_s_valid;
  logic                   o_s_ready;
  wrot_beat_u             i_s_data;
  logic                   i_s_last;
  logic                   o_m_valid;
  logic                   i_m_ready;
  logic [`WROT_M_W-1:0]   o_m_data;
  logic                   o_m_last;
  logic                   o_m_is_config;
  logic [`WROT_KW2_W-1:0] o_m_kw2;
  logic                   o_m_is_w_first;
  logic                   o_m_is_cin_last;
  logic                   o_m_is_w_last;

  integer      seed = 32'hdb9c42a1;
  logic [32:0] in_q [$];         // {last, beat} in send order
  out_beat_t   exp_q [$];
  int          limit;
  int          cycles;
  int          n_out;
  int          errors;
  logic        s_took;           // Input beat moves at the coming edge
  logic        go;

  weight_rotator UUT (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .i_s_valid       (i_s_valid),
    .o_s_ready       (o_s_ready),
    .i_s_data        (i_s_data),
    .i_s_last        (i_s_last),
    .o_m_valid       (o_m_valid),
    .i_m_ready       (i_m_ready),
    .o_m_data        (o_m_data),
    .o_m_last        (o_m_last),
    .o_m_is_config   (o_m_is_config),
    .o_m_kw2         (o_m_kw2),
    .o_m_is_w_first  (o_m_is_w_first),
    .o_m_is_cin_last (o_m_is_cin_last),
    .o_m_is_w_last   (o_m_is_w_last)
  );

  bind weight_rotator weight_rotator_chk u_chk (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_valid    (o_m_valid),
    .i_ready    (i_m_ready),
    .i_data     (o_m_data),
    .i_last     (o_m_last),
    .i_is_config(o_m_is_config),
    .i_kw2      (o_m_kw2),
    .i_w_first  (o_m_is_w_first),
    .i_cin_last (o_m_is_cin_last),
    .i_w_last   (o_m_is_w_last)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  task automatic abort_run(input string why);
    errors++;
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Random header, its weight beats and the expected output sequence
  task automatic make_packet();
    wrot_beat_u           hdr;
    logic [31:0]          r;
    logic [31:0]          v;
    int                   kw, cin, rows, max_cin, idx;
    logic [`WROT_S_W-1:0] w [$];
    out_beat_t            e;
    hdr = '0;
    r = $random(seed);
    hdr.hdr.kw2 = r[`WROT_KW2_W-1:0];
    kw = 2 * hdr.hdr.kw2 + 1;
    max_cin = `WROT_DEPTH / kw;  // Keep kw * cin within one bank
    if (max_cin > (1 << `WROT_CIN_W))
      max_cin = 1 << `WROT_CIN_W;
    r = $random(seed);
    v = r % max_cin;
    hdr.hdr.cin_1 = v[`WROT_CIN_W-1:0];
    cin = v + 1;
    r = $random(seed);
    hdr.hdr.cols_1   = r[`WROT_COLS_W-1:0];
    hdr.hdr.blocks_1 = r[8 +: `WROT_BLK_W];
    rows = kw * cin;
    v = rows - 1;
    hdr.hdr.rows_1 = v[`WROT_ADDR_W-1:0];
    in_q.push_back({1'b0, hdr});
    for (int i = 0; i < 2 * rows; i++) begin
      r = $random(seed);
      w.push_back(r);
      in_q.push_back({i == 2 * rows - 1, r});
    end
    e = '0;
    e.data      = {{(`WROT_M_W - `WROT_S_W){1'b0}}, hdr};
    e.is_config = 1'b1;
    e.kw2       = hdr.hdr.kw2;
    exp_q.push_back(e);
    e.is_config = 1'b0;
    // Kernel fastest, then channel, column, block
    for (int b = 0; b <= hdr.hdr.blocks_1; b++) begin
      for (int col = 0; col <= hdr.hdr.cols_1; col++) begin
        for (int c = 0; c < cin; c++) begin
          for (int k = 0; k < kw; k++) begin
            idx = c * kw + k;
            e.data     = {w[2 * idx + 1], w[2 * idx]};  // First beat is the low half
            e.w_first  = (col == 0) && (c == 0) && (k == 0);
            e.cin_last = (k == kw - 1) && (c == cin - 1);
            e.w_last   = (col == hdr.hdr.cols_1);
            exp_q.push_back(e);
          end
        end
      end
    end
    // Only the final row of the packet carries last
    e.last = 1'b1;
    exp_q[exp_q.size() - 1] = e;
  endtask

  task automatic check_output();
    out_beat_t got;
    out_beat_t e;
    got.data      = o_m_data;
    got.last      = o_m_last;
    got.is_config = o_m_is_config;
    got.kw2       = o_m_kw2;
    got.w_first   = o_m_is_w_first;
    got.cin_last  = o_m_is_cin_last;
    got.w_last    = o_m_is_w_last;
    assert (exp_q.size() > 0) else
      abort_run($sformatf("Unexpected output beat at %0t after all packets were done", $time));
    e = exp_q.pop_front();
    assert (got === e) else
      abort_run($sformatf(
        "CHECK FAILED at %0t: beat %0d data %h flags %b, expected data %h flags %b",
        $time, n_out, got.data, got[6:0], e.data, e[6:0]));
    n_out++;
  endtask

  // Outputs and ready are settled at the falling edge
  always @(negedge aclk) begin
    s_took = i_s_valid && o_s_ready;
    if (aresetn && o_m_valid && i_m_ready)
      check_output();
    assert (UUT.u_chk.fail_count == 0) else
      abort_run("An output stream protocol assertion failed");
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit)
      abort_run($sformatf("Timeout after %0d cycles, %0d output beats never arrived",
                          cycles, exp_q.size()));
  end

  // Single source of random stimulus, so the draw order is fixed
  initial begin
    logic [31:0] r;
    logic [32:0] beat;
    wait (go);
    forever begin
      @(posedge aclk);
      #2;
      r = $random(seed);
      i_m_ready = r[0] | r[1];  // Ready about 3 cycles in 4
      if (!i_s_valid || s_took) begin
        if (in_q.size() > 0 && r[3:2] != 2'd0) begin
          beat      = in_q.pop_front();
          i_s_data  = beat[31:0];
          i_s_last  = beat[32];
          i_s_valid = 1'b1;
        end else begin
          i_s_valid = 1'b0;   // Input gap
          i_s_last  = 1'b0;
        end
      end
    end
  end

  initial begin
    aresetn   = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    i_m_ready = 1'b0;
    s_took    = 1'b0;
    go        = 1'b0;
    cycles    = 0;
    limit     = 0;
    n_out     = 0;
    errors    = 0;
    for (int p = 0; p < N_PKT; p++)
      make_packet();
    limit = exp_q.size() * 8 + 500;
    repeat (16) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    go      = 1'b1;
    while (exp_q.size() > 0)
      @(posedge aclk);
    repeat (20) @(posedge aclk);  // Any extra beat shows up here
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
